// File: src/cache_pkg.sv
// Data cache shared definitions
`default_nettype none

package cache_pkg;

  // Cache geometry
  localparam int CACHE_SETS = 8;
  localparam int LINE_WORDS = 4;
  localparam int SET_BITS   = $clog2(CACHE_SETS);
  localparam int WORD_BITS  = $clog2(LINE_WORDS);
  localparam int TAG_BITS   = 32 - SET_BITS - WORD_BITS - 2;

  // Dirty line write buffer entries
  localparam int WB_DEPTH = 4;

  typedef logic [31:0]           address_t;
  typedef logic [31:0]           word_t;
  typedef logic [TAG_BITS-1:0]   tag_t;
  typedef logic [SET_BITS-1:0]   set_index_t;
  typedef logic [WORD_BITS-1:0]  word_index_t;
  typedef word_t [LINE_WORDS-1:0] line_data_t;

  // Coherence flag of one line
  typedef enum logic [1:0] {
    INVALID  = 2'd0,
    VALID    = 2'd1,
    MODIFIED = 2'd2
  } line_state_e;

  // Processor request as captured at the top level
  typedef struct packed {
    address_t address;
    word_t    wdata;
    logic     write;
  } cpu_request_t;

  // Evicted dirty line, address is line aligned
  typedef struct packed {
    address_t   address;
    line_data_t line;
  } wb_record_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    EVICT,
    WAIT_DRAIN,
    REFILL,
    COMPLETE
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: src/cache_line_store.sv
// Cache line storage
`timescale 1ns/1ps
`default_nettype none

module cache_line_store (
  input  wire                       i_clock,
  input  wire                       i_reset,

  input  wire cache_pkg::cpu_request_t i_request,

  input  wire                       i_fill,
  input  wire cache_pkg::line_data_t i_fill_line,
  input  wire                       i_word_write,

  output logic                      o_hit,
  output cache_pkg::line_state_e    o_state,
  output cache_pkg::word_t          o_rdata,
  output cache_pkg::wb_record_t     o_victim
);
  import cache_pkg::*;

  // Per set storage
  tag_t        tags   [CACHE_SETS];
  line_data_t  lines  [CACHE_SETS];
  line_state_e states [CACHE_SETS];

  // Request address fields
  tag_t        req_tag;
  set_index_t  req_set;
  word_index_t req_word;

  assign req_tag  = i_request.address[31 -: TAG_BITS];
  assign req_set  = i_request.address[WORD_BITS+2 +: SET_BITS];
  assign req_word = i_request.address[2 +: WORD_BITS];

  // Lookup on the addressed set
  assign o_state = states[req_set];
  assign o_hit   = (states[req_set] != INVALID) && (tags[req_set] == req_tag);
  assign o_rdata = lines[req_set][req_word];

  // Resident line of the set, rebuilt as a line aligned record
  assign o_victim.address = {tags[req_set], req_set, {(WORD_BITS + 2){1'b0}}};
  assign o_victim.line    = lines[req_set];

  // Coherence flags
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int s = 0; s < CACHE_SETS; s++) begin
        states[s] <= INVALID;
      end
    end else if (i_word_write) begin
      states[req_set] <= MODIFIED;
    end else if (i_fill) begin
      states[req_set] <= VALID;
    end
  end

  // Tag and data arrays
  always_ff @(posedge i_clock) begin
    if (i_fill) begin
      tags[req_set]  <= req_tag;
      lines[req_set] <= i_fill_line;
    end
    // Single word update, only on a resident line
    if (i_word_write) begin
      lines[req_set][req_word] <= i_request.wdata;
    end
  end

endmodule

`default_nettype wire

// File: src/cache_controller.sv
// Cache control state machine
`timescale 1ns/1ps
`default_nettype none

module cache_controller (
  input  wire                          i_clock,
  input  wire                          i_reset,

  input  wire                          i_start,
  input  wire cache_pkg::cpu_request_t i_request,

  input  wire                          i_hit,
  input  wire cache_pkg::line_state_e  i_state,
  input  wire cache_pkg::wb_record_t   i_victim,

  input  wire                          i_wb_full,
  input  wire                          i_wb_empty,

  input  wire                          i_refill_done,

  output logic                         o_fill,
  output logic                         o_word_write,
  output logic                         o_wb_push,
  output cache_pkg::wb_record_t        o_wb_record,

  output logic                         o_refill_request,
  output cache_pkg::address_t          o_refill_address,

  output logic                         o_ready,
  output logic                         o_done,
  output logic                         o_hit,
  output cache_pkg::word_t             o_rdata
);
  import cache_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // Lookup result kept until the operation completes
  logic        hit_seen;
  word_index_t req_word;

  assign req_word = i_request.address[2 +: WORD_BITS];

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (i_start) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (i_hit) begin
          state_d = COMPLETE;
        end else if (i_state == MODIFIED) begin
          state_d = EVICT;
        end else begin
          state_d = WAIT_DRAIN;
        end
      end
      // Stall here while the buffer has no room
      EVICT: begin
        if (!i_wb_full) begin
          state_d = WAIT_DRAIN;
        end
      end
      WAIT_DRAIN: begin
        if (i_wb_empty) begin
          state_d = REFILL;
        end
      end
      REFILL: begin
        if (i_refill_done) begin
          state_d = COMPLETE;
        end
      end
      COMPLETE: state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      state_q  <= IDLE;
      hit_seen <= 1'b0;
      o_ready  <= 1'b1;
      o_done   <= 1'b0;
      o_hit    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == LOOKUP) begin
        hit_seen <= i_hit;
      end
      if (state_q == IDLE && i_start) begin
        o_ready <= 1'b0;
      end else if (state_q == COMPLETE) begin
        o_ready <= 1'b1;
      end
      o_done <= (state_q == COMPLETE);
      o_hit  <= (state_q == COMPLETE) && hit_seen;
    end
  end

  // Read word comes from the resident line, which is the new one after a refill
  always_ff @(posedge i_clock) begin
    if (state_q == COMPLETE && !i_request.write) begin
      o_rdata <= i_victim.line[req_word];
    end
  end

  // Store and buffer strobes
  assign o_fill       = (state_q == REFILL) && i_refill_done;
  assign o_word_write = (state_q == COMPLETE) && i_request.write;
  assign o_wb_push    = (state_q == EVICT) && !i_wb_full;
  assign o_wb_record  = i_victim;

  // Refill of the whole line holding the request
  assign o_refill_request = (state_q == REFILL);
  assign o_refill_address = {i_request.address[31:WORD_BITS+2], {(WORD_BITS + 2){1'b0}}};

endmodule

`default_nettype wire

// File: src/write_buffer.sv
// Dirty line write buffer
`timescale 1ns/1ps
`default_nettype none

module write_buffer (
  input  wire                        i_clock,
  input  wire                        i_reset,

  input  wire                        i_push,
  input  wire cache_pkg::wb_record_t i_record,

  input  wire                        i_pop,

  output cache_pkg::wb_record_t      o_head,
  output logic                       o_empty,
  output logic                       o_full
);
  import cache_pkg::*;

  wb_record_t records [WB_DEPTH];

  logic [$clog2(WB_DEPTH)-1:0] wr_ptr;
  logic [$clog2(WB_DEPTH)-1:0] rd_ptr;
  // One extra bit so a full buffer is distinct from an empty one
  logic [$clog2(WB_DEPTH+1)-1:0] count;

  logic push_ok;
  logic pop_ok;

  assign push_ok = i_push && !o_full;
  assign pop_ok  = i_pop && !o_empty;

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      unique case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge i_clock) begin
    if (push_ok) begin
      records[wr_ptr] <= i_record;
    end
  end

  assign o_head  = records[rd_ptr];
  assign o_empty = (count == 0);
  assign o_full  = (count == WB_DEPTH);

endmodule

`default_nettype wire

// File: src/memory_port.sv
// Line memory port
`timescale 1ns/1ps
`default_nettype none

module memory_port (
  input  wire                        i_clock,
  input  wire                        i_reset,

  input  wire cache_pkg::wb_record_t i_wb_head,
  input  wire                        i_wb_empty,
  output logic                       o_wb_pop,

  input  wire                        i_refill_request,
  input  wire cache_pkg::address_t   i_refill_address,
  output logic                       o_refill_done,
  output cache_pkg::line_data_t      o_refill_line,

  output logic                       o_mem_read,
  output logic                       o_mem_write,
  output cache_pkg::address_t        o_mem_address,
  output cache_pkg::line_data_t      o_mem_wline,

  input  wire cache_pkg::line_data_t i_mem_rline,
  input  wire                        i_mem_ready,
  input  wire                        i_mem_done
);
  import cache_pkg::*;

  // Request levels, one at a time
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      o_mem_read  <= 1'b0;
      o_mem_write <= 1'b0;
    end else if (o_mem_write) begin
      if (i_mem_done) begin
        o_mem_write <= 1'b0;
      end
    end else if (o_mem_read) begin
      if (i_mem_ready) begin
        o_mem_read <= 1'b0;
      end
    end else if (!i_wb_empty) begin
      // Write-back goes first
      o_mem_write <= 1'b1;
    end else if (i_refill_request) begin
      o_mem_read <= 1'b1;
    end
  end

  // Address and write line, held while a request is up
  always_ff @(posedge i_clock) begin
    if (!o_mem_write && !o_mem_read) begin
      if (!i_wb_empty) begin
        o_mem_address <= i_wb_head.address;
        o_mem_wline   <= i_wb_head.line;
      end else begin
        o_mem_address <= i_refill_address;
      end
    end
  end

  // Head leaves the buffer once memory has taken it
  assign o_wb_pop = o_mem_write && i_mem_done;

  // Refill completes in the same cycle as the ready pulse
  assign o_refill_done = o_mem_read && i_mem_ready;
  assign o_refill_line = i_mem_rline;

endmodule

`default_nettype wire

// File: src/data_cache.sv
// Write-back data cache top
`timescale 1ns/1ps
`default_nettype none

module data_cache (
  input  wire                        i_clock,
  input  wire                        i_reset,

  // Processor side
  input  wire                        i_read,
  input  wire                        i_write,
  input  wire cache_pkg::address_t   i_address,
  input  wire cache_pkg::word_t      i_wdata,
  output logic                       o_ready,
  output logic                       o_done,
  output logic                       o_hit,
  output cache_pkg::word_t           o_rdata,

  // Memory side
  output logic                       o_mem_read,
  output logic                       o_mem_write,
  output cache_pkg::address_t        o_mem_address,
  output cache_pkg::line_data_t      o_mem_wline,
  input  wire cache_pkg::line_data_t i_mem_rline,
  input  wire                        i_mem_ready,
  input  wire                        i_mem_done
);
  import cache_pkg::*;

  cpu_request_t request_q;
  logic         start;

  logic         lookup_hit;
  line_state_e  lookup_state;
  wb_record_t   victim;
  logic         fill;
  logic         word_write;

  logic         wb_push;
  wb_record_t   wb_record;
  wb_record_t   wb_head;
  logic         wb_empty;
  logic         wb_full;
  logic         wb_pop;

  logic         refill_request;
  address_t     refill_address;
  logic         refill_done;
  line_data_t   refill_line;

  // Strobes count only while the cache is ready
  assign start = (i_read || i_write) && o_ready;

  always_ff @(posedge i_clock) begin
    if (start) begin
      request_q <= '{address: i_address, wdata: i_wdata, write: i_write};
    end
  end

  cache_line_store u_store (
    .i_clock, .i_reset,
    .i_request   (request_q),
    .i_fill      (fill),
    .i_fill_line (refill_line),
    .i_word_write(word_write),
    .o_hit       (lookup_hit),
    .o_state     (lookup_state),
    .o_rdata     (),
    .o_victim    (victim)
  );

  cache_controller u_controller (
    .i_clock, .i_reset,
    .i_start         (start),
    .i_request       (request_q),
    .i_hit           (lookup_hit),
    .i_state         (lookup_state),
    .i_victim        (victim),
    .i_wb_full       (wb_full),
    .i_wb_empty      (wb_empty),
    .i_refill_done   (refill_done),
    .o_fill          (fill),
    .o_word_write    (word_write),
    .o_wb_push       (wb_push),
    .o_wb_record     (wb_record),
    .o_refill_request(refill_request),
    .o_refill_address(refill_address),
    .o_ready, .o_done, .o_hit, .o_rdata
  );

  write_buffer u_write_buffer (
    .i_clock, .i_reset,
    .i_push  (wb_push),
    .i_record(wb_record),
    .i_pop   (wb_pop),
    .o_head  (wb_head),
    .o_empty (wb_empty),
    .o_full  (wb_full)
  );

  memory_port u_memory_port (
    .i_clock, .i_reset,
    .i_wb_head       (wb_head),
    .i_wb_empty      (wb_empty),
    .o_wb_pop        (wb_pop),
    .i_refill_request(refill_request),
    .i_refill_address(refill_address),
    .o_refill_done   (refill_done),
    .o_refill_line   (refill_line),
    .o_mem_read, .o_mem_write, .o_mem_address, .o_mem_wline,
    .i_mem_rline, .i_mem_ready, .i_mem_done
  );

endmodule

`default_nettype wire

// File: bench/line_memory_model.sv
// Behavioral line memory
`timescale 1ns/1ps
`default_nettype none

module line_memory_model (
  input  wire                        i_clock,
  input  wire                        i_reset,
  input  wire                        i_mem_read,
  input  wire                        i_mem_write,
  input  wire cache_pkg::address_t   i_mem_address,
  input  wire cache_pkg::line_data_t i_mem_wline,
  output cache_pkg::line_data_t      o_mem_rline,
  output logic                       o_mem_ready,
  output logic                       o_mem_done,
  output int                         o_write_count
);
  import cache_pkg::*;

  localparam int MEM_LINES = 1024;
  localparam int LATENCY   = 3;

  line_data_t mem [MEM_LINES];
  logic       busy;
  int         wait_count;
  logic [9:0] line_index;

  assign line_index = i_mem_address[WORD_BITS+2 +: 10];

  // Every word starts as its own byte address with a fixed mask
  initial begin
    for (int l = 0; l < MEM_LINES; l++) begin
      for (int w = 0; w < LINE_WORDS; w++) begin
        mem[l][w] = word_t'((l * LINE_WORDS + w) * 4) ^ 32'hA5A5_0000;
      end
    end
  end

  always @(posedge i_clock) begin
    if (i_reset) begin
      busy          <= 1'b0;
      wait_count    <= 0;
      o_mem_ready   <= 1'b0;
      o_mem_done    <= 1'b0;
      o_write_count <= 0;
    end else begin
      o_mem_ready <= 1'b0;
      o_mem_done  <= 1'b0;
      if (busy) begin
        if (wait_count == LATENCY - 1) begin
          busy <= 1'b0;
          if (i_mem_write) begin
            mem[line_index] <= i_mem_wline;
            o_mem_done      <= 1'b1;
            o_write_count   <= o_write_count + 1;
          end else begin
            o_mem_rline <= mem[line_index];
            o_mem_ready <= 1'b1;
          end
        end else begin
          wait_count <= wait_count + 1;
        end
      end else if ((i_mem_read || i_mem_write) && !o_mem_ready && !o_mem_done) begin
        // Request still high during the answer pulse is not a new one
        busy       <= 1'b1;
        wait_count <= 0;
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/data_cache_tb.sv
// Data cache testbench
`timescale 1ns/1ps
`default_nettype none

module data_cache_tb;
  import cache_pkg::*;

  typedef struct packed {
    logic       write;
    address_t   address;
    word_t      wdata;
    word_t      rdata;
    logic       hit;
    logic [7:0] writes;
  } test_entry_t;

  localparam int NUM_TESTS   = 14;
  localparam int CYCLE_LIMIT = 10 + NUM_TESTS * 200;

  logic        clock = 1'b0;
  logic        reset;
  logic        read;
  logic        write;
  address_t    address;
  word_t       wdata;
  logic        ready;
  logic        done;
  logic        hit;
  word_t       rdata;
  logic        mem_read;
  logic        mem_write;
  address_t    mem_address;
  line_data_t  mem_wline;
  line_data_t  mem_rline;
  logic        mem_ready;
  logic        mem_done;
  int          write_count;
  test_entry_t tests [NUM_TESTS];
  int          error_count = 0;
  int          cycle_count = 0;

  data_cache UUT (
    .i_clock(clock), .i_reset(reset),
    .i_read(read), .i_write(write), .i_address(address), .i_wdata(wdata),
    .o_ready(ready), .o_done(done), .o_hit(hit), .o_rdata(rdata),
    .o_mem_read(mem_read), .o_mem_write(mem_write),
    .o_mem_address(mem_address), .o_mem_wline(mem_wline),
    .i_mem_rline(mem_rline), .i_mem_ready(mem_ready), .i_mem_done(mem_done)
  );

  line_memory_model u_memory (
    .i_clock(clock), .i_reset(reset),
    .i_mem_read(mem_read), .i_mem_write(mem_write),
    .i_mem_address(mem_address), .i_mem_wline(mem_wline),
    .o_mem_rline(mem_rline), .o_mem_ready(mem_ready), .o_mem_done(mem_done),
    .o_write_count(write_count)
  );

  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the cache gave no o_done within %0d cycles", cycle_count);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic word_t preload_word(address_t a);
    return a ^ 32'hA5A5_0000;
  endfunction

  function automatic test_entry_t make_entry(logic w, address_t a, word_t d, word_t r,
                                             logic h, int n);
    test_entry_t e;
    e.write   = w;
    e.address = a;
    e.wdata   = d;
    e.rdata   = r;
    e.hit     = h;
    e.writes  = n[7:0];
    return e;
  endfunction

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_hit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  // One strobe, then count falling edges until o_done
  task automatic run_entry(test_entry_t t, output int latency);
    @(negedge clock);
    read    = !t.write;
    write   = t.write;
    address = t.address;
    wdata   = t.wdata;
    @(negedge clock);
    read    = 1'b0;
    write   = 1'b0;
    latency = 0;
    while (!done) begin
      @(negedge clock);
      latency++;
    end
  endtask

  initial begin
    int failed_tests;
    int errors_before;
    int latency;
    failed_tests = 0;
    reset   = 1'b1;
    read    = 1'b0;
    write   = 1'b0;
    address = '0;
    wdata   = '0;

    // Sets 0 and 1 get dirty, set 2 only sees clean displacement
    tests[0]  = make_entry(0, 32'h004, 0, preload_word(32'h004), 0, 0);
    tests[1]  = make_entry(0, 32'h00C, 0, preload_word(32'h00C), 1, 0);
    tests[2]  = make_entry(1, 32'h008, 32'h1111_2222, 0, 1, 0);
    tests[3]  = make_entry(0, 32'h008, 0, 32'h1111_2222, 1, 0);
    tests[4]  = make_entry(1, 32'h110, 32'h3333_4444, 0, 0, 0);
    tests[5]  = make_entry(0, 32'h110, 0, 32'h3333_4444, 1, 0);
    tests[6]  = make_entry(0, 32'h114, 0, preload_word(32'h114), 1, 0);
    tests[7]  = make_entry(0, 32'h020, 0, preload_word(32'h020), 0, 0);
    tests[8]  = make_entry(0, 32'h0A0, 0, preload_word(32'h0A0), 0, 0);
    tests[9]  = make_entry(0, 32'h084, 0, preload_word(32'h084), 0, 1);
    tests[10] = make_entry(0, 32'h008, 0, 32'h1111_2222, 0, 1);
    tests[11] = make_entry(0, 32'h010, 0, preload_word(32'h010), 0, 2);
    tests[12] = make_entry(0, 32'h110, 0, 32'h3333_4444, 0, 2);
    tests[13] = make_entry(0, 32'h114, 0, preload_word(32'h114), 1, 2);

    repeat (10) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    check_hit("o_ready", ready, 1'b1);
    check_hit("o_done", done, 1'b0);
    check_hit("o_hit", hit, 1'b0);
    check_hit("o_mem_read", mem_read, 1'b0);
    check_hit("o_mem_write", mem_write, 1'b0);
    $display("test 0 reset state: %s", (error_count == 0) ? "ok" : "FAILED");
    if (error_count != 0) begin
      failed_tests++;
    end

    for (int i = 0; i < NUM_TESTS; i++) begin
      errors_before = error_count;
      run_entry(tests[i], latency);
      check_hit("o_hit", hit, tests[i].hit);
      if (!tests[i].write) begin
        check_word("o_rdata", rdata, tests[i].rdata);
      end
      // Hits finish two edges after the strobe edge
      if (tests[i].hit) begin
        check_count("done latency", latency, 2);
      end
      check_count("line writes", write_count, int'(tests[i].writes));
      $display("test %0d %s %h: %s", i + 1, tests[i].write ? "write" : "read",
               tests[i].address, (error_count == errors_before) ? "ok" : "FAILED");
      if (error_count != errors_before) begin
        failed_tests++;
      end
    end

    $display("%0d tests, %0d failed, %0d check errors", NUM_TESTS + 1, failed_tests,
             error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
src/cache_pkg.sv
src/cache_line_store.sv
src/cache_controller.sv
src/write_buffer.sv
src/memory_port.sv
src/data_cache.sv
bench/line_memory_model.sv
bench/data_cache_tb.sv
